/* Makefile */
# Verilator build and run for the single-cycle CPU testbench
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module alu (
   input  wire [`CPU_DATA_WIDTH-1:0]  a,
   input  wire [`CPU_DATA_WIDTH-1:0]  b,
   input  cpuPkg::aluOp_e             aluOp,
   output logic [`CPU_DATA_WIDTH-1:0] result,
   output logic [2:0]                 nvz
);

   localparam int W = `CPU_DATA_WIDTH;
   localparam int LANES = W / 4;

   logic [W-1:0] sum, diff, addSat, subSat, redSum, paddsb;
   logic [2*W-1:0] rotWide;
   logic [3:0] shamt;
   logic [4:0] laneSum;
   logic addOvf, subOvf, vFlag;

   // Signed saturation limits
   localparam logic [W-1:0] MAX_POS = {1'b0, {(W-1){1'b1}}};
   localparam logic [W-1:0] MAX_NEG = {1'b1, {(W-1){1'b0}}};

   ////////////////////
   // Adders
   ////////////////////

   always_comb begin
      sum    = a + b;
      diff   = a - b;
      // Overflow when the result sign disagrees with the operands
      addOvf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
      subOvf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
      addSat = addOvf ? (a[W-1] ? MAX_NEG : MAX_POS) : sum;
      subSat = subOvf ? (a[W-1] ? MAX_NEG : MAX_POS) : diff;
   end

   ////////////////////
   // Nibble lanes
   ////////////////////

   always_comb begin
      redSum  = '0;
      paddsb  = '0;
      laneSum = '0;
      for (int i = 0; i < LANES; i++) begin
         // Reduction, every nibble signed and widened
         redSum = redSum + {{(W-4){a[4*i+3]}}, a[4*i +: 4]}
                         + {{(W-4){b[4*i+3]}}, b[4*i +: 4]};
         // Saturating lane add, -8 to 7
         laneSum = {a[4*i+3], a[4*i +: 4]} + {b[4*i+3], b[4*i +: 4]};
         if (laneSum[4] != laneSum[3])
            paddsb[4*i +: 4] = laneSum[4] ? 4'b1000 : 4'b0111;
         else
            paddsb[4*i +: 4] = laneSum[3:0];
      end
   end

   // Shift count from the low nibble only
   assign shamt   = b[3:0];
   assign rotWide = {a, a} >> shamt;

   always_comb begin
      vFlag = 1'b0;
      case (aluOp)
         cpuPkg::ALU_ADD: begin
            result = addSat;
            vFlag  = addOvf;
         end
         cpuPkg::ALU_SUB: begin
            result = subSat;
            vFlag  = subOvf;
         end
         cpuPkg::ALU_XOR:    result = a ^ b;
         cpuPkg::ALU_RED:    result = redSum;
         cpuPkg::ALU_SLL:    result = a << shamt;
         cpuPkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
         cpuPkg::ALU_ROR:    result = rotWide[W-1:0];
         cpuPkg::ALU_PADDSB: result = paddsb;
         default:            result = '0;
      endcase
   end

   // Raw flags, the branch unit decides what to keep
   assign nvz = {result[W-1], vFlag, result == '0};

endmodule

`default_nettype wire

/* hw/branchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module branchUnit (
   input  wire            clk,
   input  wire            reset,
   input  wire [2:0]      nvzIn,
   input  wire            flagWriteAll,
   input  wire            flagWriteZ,
   input  cpuPkg::cond_e  cond,
   input  wire            branchInst,
   output logic           taken
);

   // Stored flags with N V Z from high to low
   logic [2:0] flags;
   logic n, v, z, condMet;

   always_ff @(posedge clk) begin
      if (reset)
         flags <= '0;
      else if (flagWriteAll)
         flags <= nvzIn;
      else if (flagWriteZ)
         flags[0] <= nvzIn[0];
   end

   assign n = flags[2];
   assign v = flags[1];
   assign z = flags[0];

   // Conditions look at stored flags only
   always_comb begin
      case (cond)
         cpuPkg::COND_NE:     condMet = !z;
         cpuPkg::COND_EQ:     condMet = z;
         cpuPkg::COND_GT:     condMet = !z && !n;
         cpuPkg::COND_LT:     condMet = n;
         cpuPkg::COND_GE:     condMet = z || !n;
         cpuPkg::COND_LE:     condMet = n || z;
         cpuPkg::COND_OV:     condMet = v;
         cpuPkg::COND_UNCOND: condMet = 1'b1;
         default:             condMet = 1'b0;
      endcase
   end

   assign taken = branchInst && condMet;

endmodule

`default_nettype wire

/* hw/control.sv */
`timescale 1ns/10ps
`default_nettype none

module control (
   input  cpuPkg::opcode_e opcode,
   output cpuPkg::aluOp_e  aluOp,
   output logic            aluSrc,
   output logic            memToReg,
   output logic            regWrite,
   output logic            memWrite,
   output logic            branchInst,
   output logic            branchReg,
   output logic            flagWriteAll,
   output logic            flagWriteZ,
   output logic            pcsSel,
   output logic            byteLoad,
   output logic            halt
);

   always_comb begin
      // Idle defaults, nothing written
      aluOp        = cpuPkg::ALU_ADD;
      aluSrc       = 1'b0;
      memToReg     = 1'b0;
      regWrite     = 1'b0;
      memWrite     = 1'b0;
      branchInst   = 1'b0;
      branchReg    = 1'b0;
      flagWriteAll = 1'b0;
      flagWriteZ   = 1'b0;
      pcsSel       = 1'b0;
      byteLoad     = 1'b0;
      halt         = 1'b0;
      case (opcode)
         cpuPkg::OP_ADD, cpuPkg::OP_SUB: begin
            aluOp        = cpuPkg::aluOp_e'(opcode[2:0]);
            regWrite     = 1'b1;
            flagWriteAll = 1'b1;
         end
         cpuPkg::OP_XOR: begin
            aluOp      = cpuPkg::ALU_XOR;
            regWrite   = 1'b1;
            flagWriteZ = 1'b1;
         end
         // Shift amount from the immediate
         cpuPkg::OP_SLL, cpuPkg::OP_SRA, cpuPkg::OP_ROR: begin
            aluOp      = cpuPkg::aluOp_e'(opcode[2:0]);
            aluSrc     = 1'b1;
            regWrite   = 1'b1;
            flagWriteZ = 1'b1;
         end
         cpuPkg::OP_RED, cpuPkg::OP_PADDSB: begin
            aluOp    = cpuPkg::aluOp_e'(opcode[2:0]);
            regWrite = 1'b1;
         end
         // Address is base plus offset through the ALU adder
         cpuPkg::OP_LW: begin
            aluSrc   = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
         end
         cpuPkg::OP_SW: begin
            aluSrc   = 1'b1;
            memWrite = 1'b1;
         end
         cpuPkg::OP_LLB, cpuPkg::OP_LHB: begin
            byteLoad = 1'b1;
            regWrite = 1'b1;
         end
         cpuPkg::OP_B:
            branchInst = 1'b1;
         cpuPkg::OP_BR: begin
            branchInst = 1'b1;
            branchReg  = 1'b1;
         end
         cpuPkg::OP_PCS: begin
            pcsSel   = 1'b1;
            regWrite = 1'b1;
         end
         cpuPkg::OP_HLT:
            halt = 1'b1;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* hw/cpu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        progWrite,
   input  wire [15:0]                 progAddr,
   input  wire [`CPU_DATA_WIDTH-1:0]  progData,
   input  wire [15:0]                 dbgAddr,
   output logic [`CPU_DATA_WIDTH-1:0] dbgData,
   output logic [15:0]                pc,
   output logic                       hlt
);

   // Fetch and PC
   logic [`CPU_DATA_WIDTH-1:0] instruction;
   cpuPkg::opcode_e opcode;
   logic [15:0] pcReg, pcPlus2, branchOffset, branchTarget, nextPc, instAddr;

   // Control strobes
   cpuPkg::aluOp_e aluOp;
   logic aluSrc, memToReg, regWrite, memWrite, branchInst, branchReg;
   logic flagWriteAll, flagWriteZ, pcsSel, byteLoad, halt;

   // Register file and datapath
   logic [`CPU_REG_ADDR_WIDTH-1:0] srcReg1, srcReg2, dstReg;
   logic [`CPU_DATA_WIDTH-1:0] srcData1, srcData2, dstData;
   logic [`CPU_DATA_WIDTH-1:0] memImm, shiftImm, aluB, aluResult, memData, byteData;
   logic [2:0] nvz;
   logic taken, writeReg, dataWrite;

   ////////////////////
   // Fetch
   ////////////////////

   // Loader owns the address while it writes
   assign instAddr = progWrite ? progAddr : pcReg;
   assign opcode   = cpuPkg::opcode_e'(instruction[15:12]);

   memory #(.addrWidth(`CPU_IMEM_ADDR_WIDTH)) instMemory (
      .clk(clk), .writeEnable(progWrite), .addr(instAddr), .writeData(progData),
      .readData(instruction), .dbgAddr(16'h0000), .dbgData()
   );

   // 9-bit signed word offset, relative to PC+2
   assign pcPlus2      = pcReg + 16'd2;
   assign branchOffset = {{6{instruction[8]}}, instruction[8:0], 1'b0};
   assign branchTarget = pcPlus2 + branchOffset;

   always_comb begin
      if (halt)
         nextPc = pcReg;
      else if (taken && branchReg)
         nextPc = srcData1;
      else if (taken)
         nextPc = branchTarget;
      else
         nextPc = pcPlus2;
   end

   always_ff @(posedge clk) begin
      if (reset)
         pcReg <= '0;
      else
         pcReg <= nextPc;
   end

   assign pc  = pcReg;
   assign hlt = halt;

   control control0 (
      .opcode(opcode), .aluOp(aluOp), .aluSrc(aluSrc), .memToReg(memToReg),
      .regWrite(regWrite), .memWrite(memWrite), .branchInst(branchInst),
      .branchReg(branchReg), .flagWriteAll(flagWriteAll), .flagWriteZ(flagWriteZ),
      .pcsSel(pcsSel), .byteLoad(byteLoad), .halt(halt)
   );

   ////////////////////
   // Operands
   ////////////////////

   // rd doubles as a source for store data and byte merges
   assign dstReg  = instruction[11:8];
   assign srcReg1 = instruction[7:4];
   assign srcReg2 = (opcode == cpuPkg::OP_SW || byteLoad) ? instruction[11:8]
                                                           : instruction[3:0];

   // Memory offset is in words, shift amount is unsigned
   assign memImm   = {{11{instruction[3]}}, instruction[3:0], 1'b0};
   assign shiftImm = {12'h000, instruction[3:0]};
   assign aluB     = !aluSrc ? srcData2 : ((memToReg || memWrite) ? memImm : shiftImm);

   // No state changes while held in reset
   assign writeReg  = regWrite && !reset;
   assign dataWrite = memWrite && !reset;

   registerFile rf0 (
      .clk(clk), .reset(reset), .srcReg1(srcReg1), .srcReg2(srcReg2),
      .dstReg(dstReg), .writeReg(writeReg), .dstData(dstData),
      .srcData1(srcData1), .srcData2(srcData2)
   );

   alu alu0 (.a(srcData1), .b(aluB), .aluOp(aluOp), .result(aluResult), .nvz(nvz));

   branchUnit branch0 (
      .clk(clk), .reset(reset), .nvzIn(nvz), .flagWriteAll(flagWriteAll),
      .flagWriteZ(flagWriteZ), .cond(cpuPkg::cond_e'(instruction[11:9])),
      .branchInst(branchInst), .taken(taken)
   );

   memory #(.addrWidth(`CPU_DMEM_ADDR_WIDTH)) dataMemory (
      .clk(clk), .writeEnable(dataWrite), .addr(aluResult), .writeData(srcData2),
      .readData(memData), .dbgAddr(dbgAddr), .dbgData(dbgData)
   );

   ////////////////////
   // Write-back
   ////////////////////

   // Opcode bit 12 set means LHB
   assign byteData = instruction[12] ? {instruction[7:0], srcData2[7:0]}
                                     : {srcData2[15:8], instruction[7:0]};

   always_comb begin
      if (byteLoad)
         dstData = byteData;
      else if (pcsSel)
         dstData = pcPlus2;
      else if (memToReg)
         dstData = memData;
      else
         dstData = aluResult;
   end

   // Word aligned fetch, including register branch targets
   pcEven: assert property (@(posedge clk) disable iff (reset) pcReg[0] == 1'b0);

endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

   // Top nibble of every instruction
   typedef enum logic [3:0] {
      OP_ADD    = 4'h0,
      OP_SUB    = 4'h1,
      OP_XOR    = 4'h2,
      OP_RED    = 4'h3,
      OP_SLL    = 4'h4,
      OP_SRA    = 4'h5,
      OP_ROR    = 4'h6,
      OP_PADDSB = 4'h7,
      OP_LW     = 4'h8,
      OP_SW     = 4'h9,
      OP_LLB    = 4'hA,
      OP_LHB    = 4'hB,
      OP_B      = 4'hC,
      OP_BR     = 4'hD,
      OP_PCS    = 4'hE,
      OP_HLT    = 4'hF
   } opcode_e;

   // Same order as the low eight opcodes
   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_XOR, ALU_RED,
      ALU_SLL, ALU_SRA, ALU_ROR, ALU_PADDSB
   } aluOp_e;

   // Branch condition field, instruction bits 11:9
   typedef enum logic [2:0] {
      COND_NE, COND_EQ, COND_GT, COND_LT,
      COND_GE, COND_LE, COND_OV, COND_UNCOND
   } cond_e;

endpackage

`default_nettype wire

/* hw/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and instruction word width
`define CPU_DATA_WIDTH 16

// Register file geometry
`define CPU_REG_COUNT 16
`define CPU_REG_ADDR_WIDTH 4

// Word address bits per memory
// Byte address bit 0 is not used for indexing
`define CPU_IMEM_ADDR_WIDTH 10
`define CPU_DMEM_ADDR_WIDTH 10

`endif

/* hw/memory.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module memory #(
   parameter int addrWidth = 10
) (
   input  wire                        clk,
   input  wire                        writeEnable,
   input  wire [15:0]                 addr,
   input  wire [`CPU_DATA_WIDTH-1:0]  writeData,
   output logic [`CPU_DATA_WIDTH-1:0] readData,
   input  wire [15:0]                 dbgAddr,
   output logic [`CPU_DATA_WIDTH-1:0] dbgData
);

   // Word array, contents survive reset
   logic [`CPU_DATA_WIDTH-1:0] mem [2**addrWidth];

   // Byte address, bit 0 ignored
   always_ff @(posedge clk) begin
      if (writeEnable)
         mem[addr[addrWidth:1]] <= writeData;
   end

   // Same-cycle reads on both ports
   assign readData = mem[addr[addrWidth:1]];
   assign dbgData  = mem[dbgAddr[addrWidth:1]];

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module registerFile (
   input  wire                           clk,
   input  wire                           reset,
   input  wire [`CPU_REG_ADDR_WIDTH-1:0] srcReg1,
   input  wire [`CPU_REG_ADDR_WIDTH-1:0] srcReg2,
   input  wire [`CPU_REG_ADDR_WIDTH-1:0] dstReg,
   input  wire                           writeReg,
   input  wire [`CPU_DATA_WIDTH-1:0]     dstData,
   output logic [`CPU_DATA_WIDTH-1:0]    srcData1,
   output logic [`CPU_DATA_WIDTH-1:0]    srcData2
);

   logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

   // Register 0 is never written
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `CPU_REG_COUNT; i++)
            regs[i] <= '0;
      end else if (writeReg && dstReg != '0) begin
         regs[dstReg] <= dstData;
      end
   end

   // Asynchronous reads, no bypass of the pending write
   assign srcData1 = (srcReg1 == '0) ? '0 : regs[srcReg1];
   assign srcData2 = (srcReg2 == '0) ? '0 : regs[srcReg2];

   // Top level holds writes off during reset
   noWriteInReset: assert property (@(posedge clk) reset |-> !writeReg);

endmodule

`default_nettype wire

/* verification/cpuTb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpuTb;

   localparam int W = `CPU_DATA_WIDTH;
   localparam int MAX_PROG = 2 ** `CPU_IMEM_ADDR_WIDTH;
   localparam int HALT_LIMIT = 2000;

   logic clk, reset, progWrite, hlt;
   logic [15:0] progAddr, dbgAddr, pc;
   logic [W-1:0] progData, dbgData;

   // Program being assembled plus expected data memory words
   logic [W-1:0] prog [$];
   logic [15:0] expAddr [$];
   logic [W-1:0] expData [$];
   int errors, checks;

   cpu u_cpu (
      .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
      .progData(progData), .dbgAddr(dbgAddr), .dbgData(dbgData), .pc(pc), .hlt(hlt)
   );

   always #50 clk = ~clk;

   ////////////////////
   // Checks
   ////////////////////

   task automatic checkWord(input string name, input logic [W-1:0] exp,
                            input logic [W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s exp %h act %h", name, exp, act);
      end
   endtask

   task automatic checkPc(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s exp %h act %h", name, exp, act);
      end
   endtask

   task automatic checkBit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s exp %h act %h", name, exp, act);
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // Nibble i of x as a signed value
   function automatic int nib(input logic [W-1:0] x, input int i);
      int n;
      n = int'((x >> (4 * i)) & 16'hF);
      return (n > 7) ? n - 16 : n;
   endfunction

   function automatic logic [W-1:0] clampWord(input int s);
      if (s > 32767)
         return 16'h7FFF;
      if (s < -32768)
         return 16'h8000;
      return 16'(s);
   endfunction

   function automatic logic [W-1:0] satAdd(input logic [W-1:0] a, input logic [W-1:0] b);
      return clampWord(int'($signed(a)) + int'($signed(b)));
   endfunction

   function automatic logic [W-1:0] satSub(input logic [W-1:0] a, input logic [W-1:0] b);
      return clampWord(int'($signed(a)) - int'($signed(b)));
   endfunction

   function automatic logic [W-1:0] redModel(input logic [W-1:0] a, input logic [W-1:0] b);
      int s;
      s = 0;
      for (int i = 0; i < 4; i++)
         s += nib(a, i) + nib(b, i);
      return 16'(s);
   endfunction

   // Each lane clamped to -8..7
   function automatic logic [W-1:0] paddsbModel(input logic [W-1:0] a, input logic [W-1:0] b);
      logic [W-1:0] r;
      int s;
      r = '0;
      for (int i = 0; i < 4; i++) begin
         s = nib(a, i) + nib(b, i);
         if (s > 7)
            s = 7;
         if (s < -8)
            s = -8;
         r = r | (16'(s & 15) << (4 * i));
      end
      return r;
   endfunction

   // One bit position per step
   function automatic logic [W-1:0] shiftModel(input cpuPkg::aluOp_e op,
                                               input logic [W-1:0] a, input logic [3:0] sh);
      logic [W-1:0] r;
      r = a;
      repeat (sh) begin
         if (op == cpuPkg::ALU_SLL)
            r = {r[14:0], 1'b0};
         else if (op == cpuPkg::ALU_SRA)
            r = {r[15], r[15:1]};
         else
            r = {r[0], r[15:1]};
      end
      return r;
   endfunction

   function automatic bit condModel(input cpuPkg::cond_e c, input bit n, input bit v,
                                    input bit z);
      case (c)
         cpuPkg::COND_NE: return !z;
         cpuPkg::COND_EQ: return z;
         cpuPkg::COND_GT: return !z && !n;
         cpuPkg::COND_LT: return n;
         cpuPkg::COND_GE: return z || !n;
         cpuPkg::COND_LE: return n || z;
         cpuPkg::COND_OV: return v;
         default:         return 1'b1;
      endcase
   endfunction

   ////////////////////
   // Assembler
   ////////////////////

   function automatic logic [W-1:0] encode(input cpuPkg::opcode_e op, input logic [3:0] f1,
                                           input logic [3:0] f2, input logic [3:0] f3);
      return {op, f1, f2, f3};
   endfunction

   function automatic logic [W-1:0] encodeImm(input cpuPkg::opcode_e op, input logic [3:0] rd,
                                              input logic [7:0] imm);
      return {op, rd, imm};
   endfunction

   function automatic logic [W-1:0] encodeBranch(input cpuPkg::cond_e c, input logic [8:0] off);
      return {cpuPkg::OP_B, c, off};
   endfunction

   function automatic logic [W-1:0] encodeBr(input cpuPkg::cond_e c, input logic [3:0] rs);
      return {cpuPkg::OP_BR, c, 1'b0, rs, 4'h0};
   endfunction

   task automatic emit(input logic [W-1:0] word);
      prog.push_back(word);
   endtask

   // LLB then LHB
   task automatic setReg(input logic [3:0] r, input logic [W-1:0] value);
      emit(encodeImm(cpuPkg::OP_LLB, r, value[7:0]));
      emit(encodeImm(cpuPkg::OP_LHB, r, value[15:8]));
   endtask

   // r15 is the scratch address register
   task automatic storeReg(input logic [3:0] r, input logic [15:0] addr,
                           input logic [W-1:0] exp);
      setReg(4'd15, addr);
      emit(encode(cpuPkg::OP_SW, r, 4'd15, 4'd0));
      expAddr.push_back(addr);
      expData.push_back(exp);
   endtask

   // Both paths store the marker or its inverse
   task automatic branchCase(input cpuPkg::cond_e c, input logic [15:0] slot,
                             input logic [W-1:0] marker, input bit expTaken);
      setReg(4'd4, marker);
      setReg(4'd5, ~marker);
      setReg(4'd15, slot);
      emit(encodeBranch(c, 9'd2));
      emit(encode(cpuPkg::OP_SW, 4'd4, 4'd15, 4'd0));
      emit(encodeBranch(cpuPkg::COND_UNCOND, 9'd1));
      emit(encode(cpuPkg::OP_SW, 4'd5, 4'd15, 4'd0));
      expAddr.push_back(slot);
      expData.push_back(expTaken ? ~marker : marker);
   endtask

   ////////////////////
   // Run control
   ////////////////////

   task automatic startProgram();
      prog.delete();
      expAddr.delete();
      expData.delete();
   endtask

   // Load with reset high then release
   task automatic loadProgram();
      @(negedge clk);
      reset = 1'b1;
      if (prog.size() > MAX_PROG) begin
         errors++;
         $display("program of %0d words does not fit instruction memory", prog.size());
      end
      foreach (prog[i]) begin
         progWrite = 1'b1;
         progAddr  = 16'(2 * i);
         progData  = prog[i];
         @(negedge clk);
      end
      progWrite = 1'b0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic runToHalt(input string testName, output int cycles);
      cycles = 0;
      while (hlt !== 1'b1 && cycles < HALT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (hlt !== 1'b1) begin
         errors++;
         $display("timeout, %s never raised hlt", testName);
      end
   endtask

   task automatic checkMemory();
      foreach (expAddr[i]) begin
         @(negedge clk);
         dbgAddr = expAddr[i];
         @(posedge clk);
         checkWord($sformatf("dmem[%h]", expAddr[i]), expData[i], dbgData);
      end
   endtask

   task automatic finishProgram(input string testName);
      logic [15:0] haltAddr;
      int cycles;
      haltAddr = 16'(2 * prog.size());
      emit(encode(cpuPkg::OP_HLT, 4'h0, 4'h0, 4'h0));
      loadProgram();
      runToHalt(testName, cycles);
      checkPc("pc", haltAddr, pc);
      // Halted core holds still
      repeat (3) begin
         @(negedge clk);
         checkPc("pc", haltAddr, pc);
         checkBit("hlt", 1'b1, hlt);
      end
      checkMemory();
   endtask

   ////////////////////
   // Tests
   ////////////////////

   task automatic testArithmetic();
      logic [W-1:0] opA [5];
      logic [W-1:0] opB [5];
      logic [15:0] base;
      startProgram();
      // Random pair then overflow corners
      opA = '{16'($urandom), 16'h7000, 16'h8000, 16'h9000, 16'h7000};
      opB = '{16'($urandom), 16'h2000, 16'h0001, 16'h9000, 16'h9000};
      for (int k = 0; k < 5; k++) begin
         base = 16'(16'h0100 + 8 * k);
         setReg(4'd1, opA[k]);
         setReg(4'd2, opB[k]);
         emit(encode(cpuPkg::OP_ADD, 4'd3, 4'd1, 4'd2));
         emit(encode(cpuPkg::OP_SUB, 4'd4, 4'd1, 4'd2));
         emit(encode(cpuPkg::OP_XOR, 4'd5, 4'd1, 4'd2));
         storeReg(4'd3, base, satAdd(opA[k], opB[k]));
         storeReg(4'd4, 16'(base + 2), satSub(opA[k], opB[k]));
         storeReg(4'd5, 16'(base + 4), opA[k] ^ opB[k]);
      end
      finishProgram("arithmetic");
   endtask

   task automatic testShiftLane();
      logic [W-1:0] a, b;
      logic [3:0] sh;
      logic [15:0] base;
      startProgram();
      for (int k = 0; k < 4; k++) begin
         a    = 16'($urandom);
         b    = 16'($urandom);
         sh   = (k == 0) ? 4'h0 : (k == 1) ? 4'hF : 4'($urandom);
         base = 16'(16'h0200 + 16 * k);
         setReg(4'd1, a);
         setReg(4'd2, b);
         emit(encode(cpuPkg::OP_SLL, 4'd3, 4'd1, sh));
         emit(encode(cpuPkg::OP_SRA, 4'd4, 4'd1, sh));
         emit(encode(cpuPkg::OP_ROR, 4'd5, 4'd1, sh));
         emit(encode(cpuPkg::OP_RED, 4'd6, 4'd1, 4'd2));
         emit(encode(cpuPkg::OP_PADDSB, 4'd7, 4'd1, 4'd2));
         storeReg(4'd3, base, shiftModel(cpuPkg::ALU_SLL, a, sh));
         storeReg(4'd4, 16'(base + 2), shiftModel(cpuPkg::ALU_SRA, a, sh));
         storeReg(4'd5, 16'(base + 4), shiftModel(cpuPkg::ALU_ROR, a, sh));
         storeReg(4'd6, 16'(base + 6), redModel(a, b));
         storeReg(4'd7, 16'(base + 8), paddsbModel(a, b));
      end
      finishProgram("shift and lane");
   endtask

   task automatic testLoadStore();
      logic [W-1:0] a, b, val;
      logic [3:0] offs [4];
      logic [15:0] base, addr;
      int o;
      startProgram();
      a    = 16'($urandom);
      b    = 16'($urandom);
      base = 16'h0180;
      // Extreme and mid offsets of both signs
      offs = '{4'h3, 4'hE, 4'h7, 4'h8};
      setReg(4'd1, a);
      setReg(4'd2, b);
      setReg(4'd14, base);
      for (int i = 0; i < 4; i++) begin
         val  = (i % 2) ? b : a;
         o    = (offs[i] > 4'd7) ? int'(offs[i]) - 16 : int'(offs[i]);
         addr = 16'(int'(base) + 2 * o);
         emit(encode(cpuPkg::OP_SW, (i % 2) ? 4'd2 : 4'd1, 4'd14, offs[i]));
         expAddr.push_back(addr);
         expData.push_back(val);
         emit(encode(cpuPkg::OP_LW, 4'(6 + i), 4'd14, offs[i]));
         storeReg(4'(6 + i), 16'(16'h01C0 + 2 * i), val);
      end
      // r0 ignores every write
      emit(encodeImm(cpuPkg::OP_LLB, 4'd0, 8'h55));
      emit(encode(cpuPkg::OP_ADD, 4'd0, 4'd1, 4'd2));
      storeReg(4'd0, 16'h01C8, 16'h0000);
      finishProgram("load and store");
   endtask

   task automatic testBranches();
      logic [W-1:0] opA [4];
      logic [W-1:0] opB [4];
      logic [W-1:0] res;
      cpuPkg::cond_e c;
      int diff, idx;
      startProgram();
      // Zero, negative, positive, overflow
      opA = '{16'h0005, 16'h0003, 16'h0005, 16'h8000};
      opB = '{16'h0005, 16'h0005, 16'h0003, 16'h0001};
      for (int ci = 0; ci < 8; ci++) begin
         for (int s = 0; s < 4; s++) begin
            c    = cpuPkg::cond_e'(3'(ci));
            idx  = ci * 4 + s;
            diff = int'($signed(opA[s])) - int'($signed(opB[s]));
            res  = clampWord(diff);
            setReg(4'd1, opA[s]);
            setReg(4'd2, opB[s]);
            emit(encode(cpuPkg::OP_SUB, 4'd3, 4'd1, 4'd2));
            branchCase(c, 16'(16'h0300 + 2 * idx), 16'(16'h4000 + idx),
                       condModel(c, res[15], diff > 32767 || diff < -32768, res == '0));
         end
      end
      finishProgram("branches");
   endtask

   task automatic testPcsBr();
      logic [15:0] pcsAddr, target;
      startProgram();
      setReg(4'd1, 16'h0003);
      setReg(4'd2, 16'h0005);
      setReg(4'd8, 16'hBAD0);
      setReg(4'd9, 16'h600D);
      pcsAddr = 16'(2 * prog.size());
      emit(encodeImm(cpuPkg::OP_PCS, 4'd6, 8'h00));
      storeReg(4'd6, 16'h0400, 16'(pcsAddr + 2));
      // Good word goes first so the skipped store would clobber it
      storeReg(4'd9, 16'h0402, 16'h600D);
      // Target skips BR and the three-word bad store
      target = 16'(2 * (prog.size() + 6));
      setReg(4'd7, target);
      emit(encodeBr(cpuPkg::COND_UNCOND, 4'd7));
      setReg(4'd15, 16'h0402);
      emit(encode(cpuPkg::OP_SW, 4'd8, 4'd15, 4'd0));
      // N from SUB must survive the XOR
      emit(encode(cpuPkg::OP_SUB, 4'd3, 4'd1, 4'd2));
      emit(encode(cpuPkg::OP_XOR, 4'd3, 4'd1, 4'd1));
      branchCase(cpuPkg::COND_LT, 16'h0404, 16'h7100, 1'b1);
      branchCase(cpuPkg::COND_EQ, 16'h0406, 16'h7200, 1'b1);
      branchCase(cpuPkg::COND_GT, 16'h0408, 16'h7300, 1'b0);
      // Not taken as a jump here would restart at 0
      setReg(4'd7, 16'h0000);
      emit(encodeBr(cpuPkg::COND_NE, 4'd7));
      storeReg(4'd9, 16'h040A, 16'h600D);
      finishProgram("pcs and br");
   endtask

   task automatic testResetRerun();
      int cycles;
      startProgram();
      // Count down from 40 with two cycles per pass
      emit(encodeImm(cpuPkg::OP_LLB, 4'd1, 8'd40));
      emit(encodeImm(cpuPkg::OP_LLB, 4'd2, 8'd1));
      emit(encode(cpuPkg::OP_SUB, 4'd1, 4'd1, 4'd2));
      emit(encodeBranch(cpuPkg::COND_NE, 9'h1FE));
      emit(encode(cpuPkg::OP_HLT, 4'h0, 4'h0, 4'h0));
      loadProgram();
      repeat (10) @(negedge clk);
      checkBit("hlt", 1'b0, hlt);
      reset = 1'b1;
      @(negedge clk);
      checkPc("pc", 16'h0000, pc);
      @(negedge clk);
      reset = 1'b0;
      runToHalt("reset rerun", cycles);
      checkPc("pc", 16'h0008, pc);
      checkWord("haltCycles", 16'd82, 16'(cycles));
   endtask

   initial begin
      int unsigned seedInit;
      clk       = 1'b0;
      reset     = 1'b1;
      progWrite = 1'b0;
      progAddr  = '0;
      progData  = '0;
      dbgAddr   = '0;
      errors    = 0;
      checks    = 0;
      seedInit  = $urandom(32'h8ceb_7713);
      repeat (2) @(posedge clk);
      testArithmetic();
      testShiftLane();
      testLoadStore();
      testBranches();
      testPcsBr();
      testResetRerun();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/cpuPkg.sv
hw/memory.sv
hw/control.sv
hw/alu.sv
hw/registerFile.sv
hw/branchUnit.sv
hw/cpu.sv
verification/cpuTb.sv
